// File: source/vdc_pkg.sv
// shared enums, packed structs, default sizes and the refresh window test for the VDC RAM side
package vdc_pkg;

	localparam int VDC_RAM_AW_DEF  = 14;	// 16K video RAM
	localparam int VDC_S_LATCH_DEF = 80;	// one screen row of codes
	localparam int VDC_C_LATCH_DEF = 8;

	typedef enum logic [1:0] {
		op_none,
		op_read,
		op_write
	} ram_op_t;

	typedef enum logic [2:0] {
		ca_none,
		ca_read,
		ca_write,
		ca_fill,
		ca_copy_rd,
		ca_copy_wr
	} cpu_action_t;

	typedef enum logic [1:0] {
		fk_none,
		fk_char,
		fk_scrn,
		fk_attr
	} fetch_kind_t;

	typedef struct packed {
		ram_op_t     op;
		logic [15:0] addr;
		logic [7:0]  wdata;
	} ram_req_t;

	typedef struct packed {
		ram_req_t    req;
		fetch_kind_t kind;	// latch that takes the returned byte
	} disp_req_t;

	typedef struct packed {
		logic [7:0]  ht;	// horizontal total
		logic [7:0]  hd;	// horizontal displayed
		logic [7:0]  ai;	// address increment per row
		logic [15:0] ds;	// display start
		logic [15:0] aa;	// attribute start
		logic [2:0]  cb;	// character set base
		logic [4:0]  ctv;
		logic [3:0]  drr;	// refresh slots per line
		logic        copy;
		logic        atr;
		logic        bitmap;
	} vdc_cfg_t;

	typedef struct packed {
		logic       col_start;
		logic       col_end;
		logic       new_line;
		logic       new_row;
		logic       visible;
		logic [7:0] col;
		logic [4:0] line;
	} col_strobe_t;

	// refresh owns the columns hd .. hd+drr-1
	function automatic logic in_refresh(input logic [7:0] col, input logic [7:0] hd,
			input logic [3:0] drr);
		logic [8:0] rfsh_end;
		rfsh_end = {1'b0, hd} + {5'd0, drr};
		return (col >= hd) && ({1'b0, col} < rfsh_end);
	endfunction

endpackage

// File: source/vdc_ram.sv
`timescale 1ns/10ps
// single-port video RAM with write enable and registered read data
module vdc_ram #(
	parameter int AW = 14,
	parameter int DW = 8
)(
	input  logic          clk,
	input  logic          rd,
	input  logic          we,
	input  logic [AW-1:0] addr,
	input  logic [DW-1:0] wdata,
	output logic [DW-1:0] rdata
);

	logic [DW-1:0] mem [2**AW];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		if (rd) begin
			rdata <= mem[addr];	// holds between reads
		end
	end

endmodule

// File: source/vdc_cpu_engine.sv
`timescale 1ns/10ps
// CPU register decode for UA, WC, DA and BA plus the block read, write, fill and copy FSM
module vdc_cpu_engine import vdc_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        cpu_sel,
	input  logic        cpu_wr,
	input  logic [5:0]  reg_addr,
	input  logic [7:0]  db_in,
	input  logic        copy_mode,
	input  logic        cpu_done,
	input  logic [7:0]  ram_rdata,
	output ram_req_t    cpu_req,
	output logic [15:0] reg_ua,
	output logic [15:0] reg_ba,
	output logic [7:0]  reg_wc,
	output logic [7:0]  reg_da,
	output logic        busy
);

	localparam logic [5:0] ra_ua_hi = 6'd18;
	localparam logic [5:0] ra_ua_lo = 6'd19;
	localparam logic [5:0] ra_wc    = 6'd30;
	localparam logic [5:0] ra_da    = 6'd31;
	localparam logic [5:0] ra_ba_hi = 6'd32;
	localparam logic [5:0] ra_ba_lo = 6'd33;

	cpu_action_t cpu_action;
	logic [7:0]  wda;	// byte for write and fill
	logic [7:0]  cda;	// byte in flight during copy
	logic [7:0]  wc;	// remaining block count

	assign busy = (cpu_action != ca_none);

	always_comb begin
		cpu_req.op    = op_none;
		cpu_req.addr  = reg_ua;
		cpu_req.wdata = wda;
		case (cpu_action)
			ca_read: cpu_req.op = op_read;
			ca_write, ca_fill: cpu_req.op = op_write;
			ca_copy_rd: begin
				cpu_req.op   = op_read;
				cpu_req.addr = reg_ba;	// copy source
			end
			ca_copy_wr: begin
				cpu_req.op    = op_write;
				cpu_req.wdata = cda;
			end
			default: cpu_req.op = op_none;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cpu_action <= ca_none;
			reg_ua     <= '0;
			reg_ba     <= '0;
			reg_wc     <= '0;
			reg_da     <= '0;
			wc         <= '0;
		end else begin
			// one slot finished, step the block
			if (cpu_done) begin
				case (cpu_action)
					ca_read: begin
						reg_da     <= ram_rdata;
						cpu_action <= ca_none;
					end
					ca_write: begin
						reg_ua     <= reg_ua + 16'd1;
						cpu_action <= ca_read;	// prefetch next byte into DA
					end
					ca_fill: begin
						reg_ua     <= reg_ua + 16'd1;
						wc         <= wc - 8'd1;
						cpu_action <= (wc == 8'd1) ? ca_none : ca_fill;
					end
					ca_copy_rd: begin
						cda        <= ram_rdata;
						reg_ba     <= reg_ba + 16'd1;
						cpu_action <= ca_copy_wr;
					end
					ca_copy_wr: begin
						reg_ua     <= reg_ua + 16'd1;
						wc         <= wc - 8'd1;
						cpu_action <= (wc == 8'd1) ? ca_none : ca_copy_rd;
					end
					default: cpu_action <= ca_none;
				endcase
			end

			if (cpu_sel) begin
				if (!cpu_wr) begin
					if (reg_addr == ra_da) begin
						reg_ua     <= reg_ua + 16'd1;
						cpu_action <= ca_read;
					end
				end else begin
					case (reg_addr)
						ra_ua_hi: begin
							reg_ua[15:8] <= db_in;
							cpu_action   <= ca_read;
						end
						ra_ua_lo: begin
							reg_ua[7:0] <= db_in;
							cpu_action  <= ca_read;
						end
						ra_wc: begin
							reg_wc     <= db_in;
							wc         <= db_in;
							cpu_action <= copy_mode ? ca_copy_rd : ca_fill;
						end
						ra_da: begin
							wda        <= db_in;
							cpu_action <= ca_write;
						end
						ra_ba_hi: reg_ba[15:8] <= db_in;
						ra_ba_lo: reg_ba[7:0]  <= db_in;
						default: ;	// other registers live elsewhere
					endcase
				end
			end
		end
	end

endmodule

// File: source/vdc_display_fetch.sv
`timescale 1ns/10ps
// display row address counters, double-buffered screen and attribute latches, character fetch
module vdc_display_fetch import vdc_pkg::*; #(
	parameter int S_LATCH = VDC_S_LATCH_DEF,
	parameter int C_LATCH = VDC_C_LATCH_DEF
)(
	input  logic        clk,
	input  logic        reset,
	input  vdc_cfg_t    cfg,
	input  col_strobe_t timing,
	input  logic        disp_done,
	input  fetch_kind_t done_kind,
	input  logic [7:0]  ram_rdata,
	output disp_req_t   disp_req,
	output logic [7:0]  char_data,
	output logic        rowbuf,
	output logic [15:0] dispaddr
);

	localparam int SW = (S_LATCH > 1) ? $clog2(S_LATCH) : 1;
	localparam int CW = (C_LATCH > 1) ? $clog2(C_LATCH) : 1;

	logic [7:0]    scrnbuf [2][S_LATCH];
	logic [7:0]    attrbuf [2][S_LATCH];
	logic [7:0]    charbuf [C_LATCH];
	logic [15:0]   scrnaddr;	// row being prefetched
	logic [15:0]   attraddr;
	logic [15:0]   bmaddr;	// bitmap line start
	logic [7:0]    s_idx;
	logic [7:0]    a_idx;
	logic          was_visible;
	logic          line_edge;
	logic          cur_buf;
	logic [15:0]   bm_next;
	logic [15:0]   bm_cur;
	logic [CW-1:0] char_idx;
	logic [7:0]    code;
	logic [7:0]    attr;
	logic          en_char;
	logic          en_scac;
	logic [15:0]   char_addr;

	assign line_edge = timing.new_line || timing.new_row;
	assign cur_buf   = rowbuf ^ (timing.col_start && timing.new_row);	// swap takes effect now
	assign bm_next   = (timing.visible && was_visible) ? bmaddr + 16'(cfg.hd) + 16'(cfg.ai)
		: cfg.ds;
	assign bm_cur    = line_edge ? bm_next : bmaddr;
	assign char_idx  = CW'(timing.col % C_LATCH);
	assign char_data = charbuf[char_idx];

	assign code = (timing.col < S_LATCH) ? scrnbuf[cur_buf][SW'(timing.col)] : 8'h00;
	assign attr = (timing.col < S_LATCH) ? attrbuf[cur_buf][SW'(timing.col)] : 8'h00;

	assign en_char = timing.visible && (timing.col < cfg.hd);
	assign en_scac = !timing.new_row && !in_refresh(timing.col, cfg.hd, cfg.drr)
		&& (timing.col >= 8'd2) && ({1'b0, timing.col} + 9'd2 < {1'b0, cfg.ht});

	always_comb begin
		if (cfg.bitmap) begin
			char_addr = bm_cur + 16'(timing.col);
		end else if (cfg.ctv[4]) begin
			char_addr = {cfg.cb[2:1], cfg.atr & attr[7], code, timing.line};	// 32-line cells
		end else begin
			char_addr = {cfg.cb, cfg.atr & attr[7], code, timing.line[3:0]};
		end
	end

	always_comb begin
		disp_req.req.op    = op_none;
		disp_req.req.addr  = char_addr;
		disp_req.req.wdata = 8'h00;
		disp_req.kind      = fk_none;
		if (timing.col_start) begin
			if (en_char) begin
				disp_req.req.op = op_read;
				disp_req.kind   = fk_char;
			end else if (en_scac && s_idx < cfg.hd) begin
				disp_req.req.op   = op_read;
				disp_req.req.addr = scrnaddr + 16'(s_idx);
				disp_req.kind     = fk_scrn;
			end else if (en_scac && a_idx < cfg.hd) begin
				disp_req.req.op   = op_read;
				disp_req.req.addr = attraddr + 16'(a_idx);
				disp_req.kind     = fk_attr;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rowbuf      <= 1'b0;
			s_idx       <= 8'hff;	// nothing to fetch until the first row
			a_idx       <= 8'hff;
			scrnaddr    <= '0;
			attraddr    <= '0;
			bmaddr      <= '0;
			was_visible <= 1'b0;
			dispaddr    <= '0;
		end else begin
			if (timing.col_start && line_edge) begin
				bmaddr      <= bm_next;
				was_visible <= timing.visible;
			end
			if (timing.col_start && timing.new_row) begin
				rowbuf   <= ~rowbuf;
				s_idx    <= cfg.bitmap ? 8'hff : 8'h00;
				a_idx    <= cfg.atr ? 8'h00 : 8'hff;
				scrnaddr <= timing.visible ? scrnaddr + 16'(cfg.hd) + 16'(cfg.ai) : cfg.ds;
				attraddr <= timing.visible ? attraddr + 16'(cfg.hd) + 16'(cfg.ai) : cfg.aa;
				dispaddr <= cfg.bitmap ? bm_next : scrnaddr;
			end
			if (disp_done && done_kind == fk_scrn) begin
				s_idx <= s_idx + 8'd1;
			end
			if (disp_done && done_kind == fk_attr) begin
				a_idx <= a_idx + 8'd1;
			end
		end
	end

	// returned bytes go to the latch named by the kind, next row fills the idle buffer
	always_ff @(posedge clk) begin
		if (disp_done) begin
			case (done_kind)
				fk_char: charbuf[char_idx] <= ram_rdata;
				fk_scrn: begin
					if (s_idx < S_LATCH) begin
						scrnbuf[~rowbuf][SW'(s_idx)] <= ram_rdata;
					end
				end
				fk_attr: begin
					if (a_idx < S_LATCH) begin
						attrbuf[~rowbuf][SW'(a_idx)] <= ram_rdata;
					end
				end
				default: ;
			endcase
		end
	end

endmodule

// File: source/vdc_slot_arbiter.sv
`timescale 1ns/10ps
// per-column RAM slot arbiter with refresh blanking, RAM drive and read data return
module vdc_slot_arbiter import vdc_pkg::*; #(
	parameter int AW = VDC_RAM_AW_DEF
)(
	input  logic          clk,
	input  logic          reset,
	input  col_strobe_t   timing,
	input  vdc_cfg_t      cfg,
	input  disp_req_t     disp_req,
	input  ram_req_t      cpu_req,
	input  logic [7:0]    ram_rdata_raw,
	output logic          ram_rd,
	output logic          ram_we,
	output logic [AW-1:0] ram_addr,
	output logic [7:0]    ram_wdata,
	output logic          disp_done,
	output logic          cpu_done,
	output fetch_kind_t   done_kind,
	output logic [7:0]    ram_rdata
);

	logic        rfsh;
	logic        grant_disp;
	logic        grant_cpu;
	ram_req_t    sel_req;
	fetch_kind_t slot_kind;	// display owner of this column
	logic        slot_cpu;

	assign rfsh       = in_refresh(timing.col, cfg.hd, cfg.drr);
	assign grant_disp = (disp_req.req.op != op_none);
	assign grant_cpu  = !grant_disp && (cpu_req.op != op_none) && !rfsh;	// cpu waits out refresh
	assign sel_req    = grant_disp ? disp_req.req : cpu_req;

	always_ff @(posedge clk) begin
		if (reset) begin
			ram_rd    <= 1'b0;
			ram_we    <= 1'b0;
			slot_kind <= fk_none;
			slot_cpu  <= 1'b0;
		end else begin
			ram_rd <= 1'b0;
			ram_we <= 1'b0;
			if (timing.col_start) begin
				ram_rd    <= (grant_disp || grant_cpu) && (sel_req.op == op_read);
				ram_we    <= (grant_disp || grant_cpu) && (sel_req.op == op_write);
				slot_kind <= grant_disp ? disp_req.kind : fk_none;
				slot_cpu  <= grant_cpu;
			end else if (timing.col_end) begin
				slot_kind <= fk_none;
				slot_cpu  <= 1'b0;
			end
		end
	end

	// address and write data of the request that wins the column
	always_ff @(posedge clk) begin
		if (timing.col_start) begin
			ram_addr  <= AW'(sel_req.addr);
			ram_wdata <= sel_req.wdata;
		end
	end

	assign disp_done = timing.col_end && (slot_kind != fk_none);
	assign cpu_done  = timing.col_end && slot_cpu;
	assign done_kind = slot_kind;
	assign ram_rdata = ram_rdata_raw;	// RAM holds it until the next read

endmodule

// File: source/vdc_ram_subsys.sv
`timescale 1ns/10ps
// VDC RAM subsystem top with CPU engine, display fetch, slot arbiter and video RAM
module vdc_ram_subsys import vdc_pkg::*; #(
	parameter int RAM_AW  = VDC_RAM_AW_DEF,
	parameter int S_LATCH = VDC_S_LATCH_DEF,
	parameter int C_LATCH = VDC_C_LATCH_DEF
)(
	input  logic        clk,
	input  logic        reset,
	input  logic        cpu_sel,
	input  logic        cpu_wr,
	input  logic [5:0]  reg_addr,
	input  logic [7:0]  db_in,
	input  vdc_cfg_t    cfg,
	input  col_strobe_t timing,
	output logic [15:0] reg_ua,
	output logic [15:0] reg_ba,
	output logic [7:0]  reg_wc,
	output logic [7:0]  reg_da,
	output logic        busy,
	output logic [7:0]  char_data,
	output logic        rowbuf,
	output logic [15:0] dispaddr
);

	ram_req_t          cpu_req;
	disp_req_t         disp_req;
	logic              cpu_done;
	logic              disp_done;
	fetch_kind_t       done_kind;
	logic              ram_rd;
	logic              ram_we;
	logic [RAM_AW-1:0] ram_addr;
	logic [7:0]        ram_wdata;
	logic [7:0]        ram_rdata_raw;
	logic [7:0]        ram_rdata;

	vdc_cpu_engine u_cpu (
		.clk(clk), .reset(reset),
		.cpu_sel(cpu_sel), .cpu_wr(cpu_wr), .reg_addr(reg_addr), .db_in(db_in),
		.copy_mode(cfg.copy),
		.cpu_done(cpu_done), .ram_rdata(ram_rdata),
		.cpu_req(cpu_req),
		.reg_ua(reg_ua), .reg_ba(reg_ba), .reg_wc(reg_wc), .reg_da(reg_da),
		.busy(busy)
	);

	vdc_display_fetch #(.S_LATCH(S_LATCH), .C_LATCH(C_LATCH)) u_fetch (
		.clk(clk), .reset(reset), .cfg(cfg), .timing(timing),
		.disp_done(disp_done), .done_kind(done_kind), .ram_rdata(ram_rdata),
		.disp_req(disp_req), .char_data(char_data), .rowbuf(rowbuf), .dispaddr(dispaddr)
	);

	vdc_slot_arbiter #(.AW(RAM_AW)) u_arb (
		.clk(clk), .reset(reset), .timing(timing), .cfg(cfg),
		.disp_req(disp_req), .cpu_req(cpu_req), .ram_rdata_raw(ram_rdata_raw),
		.ram_rd(ram_rd), .ram_we(ram_we), .ram_addr(ram_addr), .ram_wdata(ram_wdata),
		.disp_done(disp_done), .cpu_done(cpu_done), .done_kind(done_kind),
		.ram_rdata(ram_rdata)
	);

	vdc_ram #(.AW(RAM_AW), .DW(8)) u_ram (
		.clk(clk), .rd(ram_rd), .we(ram_we), .addr(ram_addr),
		.wdata(ram_wdata), .rdata(ram_rdata_raw)
	);

endmodule

// File: sim/vdc_tb_properties.sv
`timescale 1ns/10ps
// concurrent checks on RAM strobes, busy after reset and done pulse exclusivity
module vdc_tb_properties (
	input logic clk,
	input logic reset,
	input logic busy,
	input logic ram_rd,
	input logic ram_we,
	input logic cpu_done,
	input logic disp_done
);

	// one RAM access per slot, never a read and a write at once
	a_rd_we_excl: assert property (@(posedge clk) disable iff (reset)
		!(ram_rd && ram_we))
		else $error("ram_rd and ram_we are high in the same cycle");

	a_busy_reset: assert property (@(posedge clk)
		reset |=> !busy)	// reset clears the engine action
		else $error("busy is high while reset is applied");

	// a column has a single owner
	a_done_excl: assert property (@(posedge clk) disable iff (reset)
		!(cpu_done && disp_done))
		else $error("cpu_done and disp_done fire together");

endmodule

// File: sim/vdc_tb.sv
`timescale 1ns/10ps
// testbench for the VDC RAM subsystem with model RAM, timing tasks, compare tasks and watchdog
module vdc_tb import vdc_pkg::*; ();

	localparam int RAM_AW        = VDC_RAM_AW_DEF;
	localparam int CLK_NS        = 100;
	localparam int NUM_TESTS     = 6;
	localparam int COLS_PER_TEST = 400;
	localparam int CYC_PER_COL   = 5;
	localparam int WATCHDOG_NS   = NUM_TESTS * COLS_PER_TEST * CYC_PER_COL * CLK_NS;
	localparam int IDLE_LIMIT    = 64;	// columns allowed for one CPU action
	localparam logic [7:0] HT       = 8'd40;
	localparam logic [7:0] HD       = 8'd16;
	localparam logic [3:0] DRR      = 4'd4;
	localparam logic [7:0] IDLE_COL = HT - 8'd1;	// no display fetch and no refresh here

	logic        clk;
	logic        reset;
	logic        cpu_sel;
	logic        cpu_wr;
	logic [5:0]  reg_addr;
	logic [7:0]  db_in;
	vdc_cfg_t    cfg;
	col_strobe_t timing;
	logic [15:0] reg_ua;
	logic [15:0] reg_ba;
	logic [7:0]  reg_wc;
	logic [7:0]  reg_da;
	logic        busy;
	logic [7:0]  char_data;
	logic        rowbuf;
	logic [15:0] dispaddr;

	int          byte_errs;
	int          addr_errs;
	int          flag_errs;
	int          misc_errs;
	logic [31:0] lcg_state;
	logic [7:0]  model_mem [2**RAM_AW];	// mirror of every RAM write

	vdc_ram_subsys #(
		.RAM_AW(RAM_AW), .S_LATCH(VDC_S_LATCH_DEF), .C_LATCH(VDC_C_LATCH_DEF)
	) DUT (
		.clk(clk), .reset(reset),
		.cpu_sel(cpu_sel), .cpu_wr(cpu_wr), .reg_addr(reg_addr), .db_in(db_in),
		.cfg(cfg), .timing(timing),
		.reg_ua(reg_ua), .reg_ba(reg_ba), .reg_wc(reg_wc), .reg_da(reg_da),
		.busy(busy), .char_data(char_data), .rowbuf(rowbuf), .dispaddr(dispaddr)
	);

	bind vdc_ram_subsys vdc_tb_properties u_props (
		.clk(clk), .reset(reset), .busy(busy), .ram_rd(ram_rd), .ram_we(ram_we),
		.cpu_done(cpu_done), .disp_done(disp_done)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	function automatic logic [7:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	function automatic logic [RAM_AW-1:0] ram_idx(input logic [15:0] a);
		return a[RAM_AW-1:0];	// RAM ignores the upper address bits
	endfunction

	task automatic check_byte(input logic [7:0] act, input logic [7:0] exp, input string what);
		if (act !== exp) begin
			$display("ERR %0t ns: %s is %02h, expected %02h", $time, what, act, exp);
			byte_errs++;
		end
	endtask

	task automatic check_addr(input logic [15:0] act, input logic [15:0] exp, input string what);
		if (act !== exp) begin
			$display("ERR %0t ns: %s is %04h, expected %04h", $time, what, act, exp);
			addr_errs++;
		end
	endtask

	task automatic check_flag(input logic act, input logic exp, input string what);
		if (act !== exp) begin
			$display("ERR %0t ns: %s is %b, expected %b", $time, what, act, exp);
			flag_errs++;
		end
	endtask

	task automatic run_column(input logic [7:0] col, input logic vis, input logic nl,
			input logic nr, input logic [4:0] line);
		@(posedge clk);
		timing.col_start <= 1'b1;
		timing.col       <= col;
		timing.visible   <= vis;
		timing.new_line  <= nl;
		timing.new_row   <= nr;
		timing.line      <= line;
		@(posedge clk);
		timing.col_start <= 1'b0;
		timing.new_line  <= 1'b0;
		timing.new_row   <= 1'b0;
		repeat (3) @(posedge clk);
		timing.col_end <= 1'b1;	// 4 cycles after col_start
		@(posedge clk);
		timing.col_end <= 1'b0;
	endtask

	task automatic reg_write(input logic [5:0] addr, input logic [7:0] data);
		@(posedge clk);
		cpu_sel  <= 1'b1;
		cpu_wr   <= 1'b1;
		reg_addr <= addr;
		db_in    <= data;
		@(posedge clk);
		cpu_sel <= 1'b0;
	endtask

	// the port returns the DA byte latched before the access
	task automatic reg_read(input logic [5:0] addr, output logic [7:0] data);
		@(negedge clk);
		data = reg_da;
		@(posedge clk);
		cpu_sel  <= 1'b1;
		cpu_wr   <= 1'b0;
		reg_addr <= addr;
		@(posedge clk);
		cpu_sel <= 1'b0;
	endtask

	task automatic wait_idle();
		int cols;
		cols = 0;
		@(negedge clk);
		while (busy && cols < IDLE_LIMIT) begin
			run_column(IDLE_COL, 1'b0, 1'b0, 1'b0, 5'd0);
			cols++;
			@(negedge clk);
		end
		if (busy) begin
			$display("busy did not fall within %0d idle columns at %0t ns",
				IDLE_LIMIT, $time);
			misc_errs++;
		end
	endtask

	task automatic set_ua(input logic [15:0] addr);
		reg_write(6'd18, addr[15:8]);
		reg_write(6'd19, addr[7:0]);
		wait_idle();
	endtask

	task automatic write_block(input logic [15:0] addr, input int n, input logic [7:0] mask);
		logic [7:0] v;
		set_ua(addr);
		for (int i = 0; i < n; i++) begin
			v = lcg_next() & mask;
			model_mem[ram_idx(addr + 16'(i))] = v;
			reg_write(6'd31, v);
			wait_idle();
		end
	endtask

	task automatic check_block(input logic [15:0] addr, input int n);
		logic [7:0] rd;
		set_ua(addr);
		for (int i = 0; i < n; i++) begin
			reg_read(6'd31, rd);
			check_byte(rd, model_mem[ram_idx(addr + 16'(i))],
				$sformatf("DA at %04h", addr + 16'(i)));
			wait_idle();
		end
	endtask

	task automatic test_write_read();
		write_block(16'h1000, 8, 8'hff);
		check_addr(reg_ua, 16'h1008, "UA after writes");
		check_block(16'h1000, 8);
		check_addr(reg_ua, 16'h1008, "UA after reads");
	endtask

	task automatic test_fill();
		logic [7:0] v;
		v = lcg_next();
		set_ua(16'h1100);
		reg_write(6'd31, v);	// lands at UA, fill continues from UA+1
		wait_idle();
		reg_write(6'd30, 8'd12);
		wait_idle();
		for (int i = 0; i <= 12; i++) begin
			model_mem[ram_idx(16'h1100 + 16'(i))] = v;
		end
		check_addr(reg_ua, 16'h110d, "UA after fill");
		check_byte(reg_wc, 8'd12, "WC after fill");
		check_block(16'h1100, 13);
	endtask

	task automatic test_copy();
		write_block(16'h1040, 8, 8'hff);
		reg_write(6'd32, 8'h10);
		reg_write(6'd33, 8'h40);
		set_ua(16'h1200);
		@(posedge clk);
		cfg.copy <= 1'b1;
		reg_write(6'd30, 8'd8);
		wait_idle();
		@(posedge clk);
		cfg.copy <= 1'b0;
		for (int i = 0; i < 8; i++) begin
			model_mem[ram_idx(16'h1200 + 16'(i))] = model_mem[ram_idx(16'h1040 + 16'(i))];
		end
		check_addr(reg_ba, 16'h1048, "BA after copy");
		check_addr(reg_ua, 16'h1208, "UA after copy");
		check_block(16'h1200, 8);
	endtask

	task automatic test_refresh();
		logic [7:0] v;
		v = lcg_next();
		set_ua(16'h1300);
		model_mem[ram_idx(16'h1300)] = v;
		reg_write(6'd31, v);
		for (int i = 0; i < 8; i++) begin
			run_column(HD + 8'(i % int'(DRR)), 1'b0, 1'b0, 1'b0, 5'd0);
			@(negedge clk);
			check_flag(busy, 1'b1, "busy in refresh column");
		end
		check_addr(reg_ua, 16'h1300, "UA held by refresh");
		run_column(IDLE_COL, 1'b0, 1'b0, 1'b0, 5'd0);
		@(negedge clk);
		check_addr(reg_ua, 16'h1301, "UA after write slot");
		wait_idle();
		check_block(16'h1300, 1);
	endtask

	task automatic test_bitmap();
		write_block(16'h0400, int'(HD), 8'hff);
		@(posedge clk);
		cfg.bitmap <= 1'b1;
		cfg.ds     <= 16'h0400;
		for (int col = 0; col < int'(HD); col++) begin
			run_column(8'(col), 1'b1, 1'b0, col == 0, 5'd0);
			@(negedge clk);
			check_byte(char_data, model_mem[ram_idx(16'h0400 + 16'(col))],
				$sformatf("bitmap char_data col %0d", col));
		end
		check_addr(dispaddr, 16'h0400, "bitmap row address");
		@(posedge clk);
		cfg.bitmap <= 1'b0;
	endtask

	task automatic test_text();
		logic       prev;
		logic [7:0] code;
		write_block(16'h0600, int'(HD), 8'h03);	// codes 0 to 3
		write_block(16'h2000, 64, 8'hff);	// font base from cb = 1
		@(posedge clk);
		cfg.ds <= 16'h0600;
		@(negedge clk);
		prev = rowbuf;
		// blank row fetches the screen codes
		for (int col = 0; col < int'(HT); col++) begin
			run_column(8'(col), 1'b0, 1'b0, col == 0, 5'd0);
		end
		@(negedge clk);
		check_flag(rowbuf, ~prev, "rowbuf after first new_row");
		for (int ln = 0; ln < 2; ln++) begin
			for (int col = 0; col < int'(HD); col++) begin
				run_column(8'(col), 1'b1, ln != 0 && col == 0, ln == 0 && col == 0, 5'(ln));
				@(negedge clk);
				code = model_mem[ram_idx(16'h0600 + 16'(col))];
				check_byte(char_data, model_mem[ram_idx(16'h2000 + 16'({code, 4'(ln)}))],
					$sformatf("text char_data line %0d col %0d", ln, col));
			end
		end
		check_flag(rowbuf, prev, "rowbuf after second new_row");
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		byte_errs = 0;
		addr_errs = 0;
		flag_errs = 0;
		misc_errs = 0;
		lcg_state = 32'd86;
		reset     = 1'b1;
		cpu_sel   = 1'b0;
		cpu_wr    = 1'b0;
		reg_addr  = '0;
		db_in     = '0;
		timing    = '0;
		cfg       = '{ht: HT, hd: HD, ai: 8'd0, ds: 16'h0000, aa: 16'h0800, cb: 3'd1,
			ctv: 5'd15, drr: DRR, copy: 1'b0, atr: 1'b0, bitmap: 1'b0};
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		test_write_read();
		test_fill();
		test_copy();
		test_refresh();
		test_bitmap();
		test_text();
		$display("errors: byte %0d, addr %0d, flag %0d, other %0d",
			byte_errs, addr_errs, flag_errs, misc_errs);
		if (byte_errs + addr_errs + flag_errs + misc_errs == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: flist.f
source/vdc_pkg.sv
source/vdc_ram.sv
source/vdc_cpu_engine.sv
source/vdc_display_fetch.sv
source/vdc_slot_arbiter.sv
source/vdc_ram_subsys.sv
sim/vdc_tb_properties.sv
sim/vdc_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the VDC RAM testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module vdc_tb -f flist.f -o vdc_sim || exit 1
out="$(./obj_dir/vdc_sim 2>&1)"
echo "$out"
echo "$out" | grep -qx "Testbench passed" && echo "simulation PASS" || { echo "simulation FAIL"; exit 1; }
